//--- div_testdata.txt
# each line holds dividend divisor signed-bit quotient remainder
# all values in hex, signed bit 1 selects signed mode
00000064 00000007 0 0000000E 00000002
FFFFFFFF 00000010 0 0FFFFFFF 0000000F
80000000 00000003 0 2AAAAAAA 00000002
12345678 00000001 0 12345678 00000000
00000005 0000000A 0 00000000 00000005
DEADBEEF 00010000 0 0000DEAD 0000BEEF
80000000 FFFFFFFF 0 00000000 80000000
FFFFFFFF 00000005 0 33333333 00000000
00000000 00000000 0 FFFFFFFF 00000000
0000002A 00000000 0 FFFFFFFF 0000002A
00000007 00000002 1 00000003 00000001
FFFFFFF9 00000002 1 FFFFFFFD FFFFFFFF
00000007 FFFFFFFE 1 FFFFFFFD 00000001
FFFFFFF9 FFFFFFFE 1 00000003 FFFFFFFF
FFFFFF9C 00000007 1 FFFFFFF2 FFFFFFFE
80000000 FFFFFFFF 1 80000000 00000000
80000000 00000001 1 80000000 00000000
80000000 00000002 1 C0000000 00000000
7FFFFFFF 00000010 1 07FFFFFF 0000000F
FFFFFFFF 00000005 1 00000000 FFFFFFFF
00000000 FFFFFFFF 1 00000000 00000000
FFFFFFF9 00000000 1 FFFFFFFF FFFFFFF9
00000011 00000000 1 FFFFFFFF 00000011

//--- all.f
div_pkg.sv
apb_regs_pkg.sv
div_cell.sv
div_pipe.sv
div_apb_slave.sv
div_result_queue.sv
div_apb_top.sv
tb_div_apb_top.sv

//--- Bender.yml
package:
  name: div_apb

sources:
  - files:
      - div_pkg.sv
      - apb_regs_pkg.sv
      - div_cell.sv
      - div_pipe.sv
      - div_apb_slave.sv
      - div_result_queue.sv
      - div_apb_top.sv
  - target: test
    files:
      - tb_div_apb_top.sv

//--- tb_div_apb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_apb_top;
    import div_pkg::*;
    import apb_regs_pkg::*;

    localparam int POLL_LIMIT = 200;        // cycles or polls per wait
    localparam int RAND_OPS = 200;
    localparam int RAND_LOOP_LIMIT = 5000;

    logic      clk;
    logic      rstn;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_addr_t paddr;
    apb_data_t pwdata;
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;

    int    checks;
    int    errors;
    int    test_mark;
    word_t v_dvd[$];
    word_t v_dvs[$];
    word_t v_sgn[$];
    word_t v_q[$];
    word_t v_r[$];
    word_t exp_q[$];                        // results in issue order

    div_apb_top UUT (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    always #10 clk = ~clk;

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %s, %0d errors", num, name,
                 (errors == test_mark) ? "ok" : "mismatches", errors - test_mark);
        test_mark = errors;
    endtask

    // RISC-V division rules, signed ops truncate toward zero
    function automatic word_t ref_div(input word_t dvd, input word_t dvs, input logic sgn,
                                      input logic rem);
        logic signed [XLEN-1:0] sd;
        logic signed [XLEN-1:0] sv;
        word_t                  q;
        word_t                  r;
        sd = dvd;
        sv = dvs;
        if (dvs == '0) begin
            q = '1;
            r = dvd;
        end else if (sgn && dvd == {1'b1, {(XLEN-1){1'b0}}} && dvs == '1) begin
            q = dvd;                        // overflow case
            r = '0;
        end else if (sgn) begin
            q = sd / sv;
            r = sd % sv;
        end else begin
            q = dvd / dvs;
            r = dvd % dvs;
        end
        return rem ? r : q;
    endfunction

    // setup phase, then access phase until pready, sampled at the falling edge
    task automatic apb_xfer(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
        int n;
        psel = 1'b1;
        penable = 1'b0;
        pwrite = wr;
        paddr = addr;
        pwdata = wdata;
        @(posedge clk);
        #2 penable = 1'b1;
        n = 0;
        @(negedge clk);
        check_word("pready", word_t'(pready), 1);   // zero wait states
        while (!pready && n < POLL_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (!pready)
            abort_run("APB transfer never completed because pready stayed low");
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #2 psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic reg_write(input apb_addr_t addr, input apb_data_t data, input logic exp_err);
        apb_data_t dummy;
        logic      err;
        apb_xfer(1'b1, addr, data, dummy, err);
        check_word("pslverr", word_t'(err), word_t'(exp_err));
    endtask

    task automatic reg_read(input apb_addr_t addr, output apb_data_t data, input logic exp_err);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_word("pslverr", word_t'(err), word_t'(exp_err));
    endtask

    task automatic issue(input word_t dvd, input word_t dvs, input logic sgn, input logic rem);
        apb_data_t cmd;
        cmd = '0;
        cmd[CMD_SIGNED_BIT] = sgn;
        cmd[CMD_REM_BIT] = rem;
        reg_write(ADDR_DIVIDEND, dvd, 1'b0);
        reg_write(ADDR_DIVISOR, dvs, 1'b0);
        reg_write(ADDR_CMD, cmd, 1'b0);
    endtask

    task automatic wait_count(input int want, output apb_data_t st);
        int n;
        n = 0;
        reg_read(ADDR_STATUS, st, 1'b0);
        while (st[COUNT_W-1:0] < want && n < POLL_LIMIT) begin
            reg_read(ADDR_STATUS, st, 1'b0);
            n++;
        end
        if (st[COUNT_W-1:0] < want)
            abort_run("STATUS count never reached the expected value");
    endtask

    task automatic run_one(input word_t dvd, input word_t dvs, input logic sgn, input logic rem,
                           output word_t res);
        apb_data_t st;
        issue(dvd, dvs, sgn, rem);
        wait_count(1, st);
        reg_read(ADDR_RESULT, res, 1'b0);
    endtask

    task automatic load_vectors();
        int    fd;
        int    n;
        string line;
        word_t f[5];
        fd = $fopen("div_testdata.txt", "r");
        if (fd == 0)
            abort_run("could not open div_testdata.txt");
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%h %h %h %h %h", f[0], f[1], f[2], f[3], f[4]);
                if (n == 5) begin
                    v_dvd.push_back(f[0]);
                    v_dvs.push_back(f[1]);
                    v_sgn.push_back(f[2]);
                    v_q.push_back(f[3]);
                    v_r.push_back(f[4]);
                end
            end
        end
        $fclose(fd);
    endtask

    // mode 0 unsigned, 1 signed, 2 any vector with a zero divisor
    task automatic file_tests(input int mode);
        word_t q;
        word_t r;
        logic  pick;
        for (int i = 0; i < v_dvd.size(); i++) begin
            if (mode == 2)
                pick = (v_dvs[i] == '0);
            else
                pick = (v_dvs[i] != '0) && (v_sgn[i][0] == mode[0]);
            if (pick) begin
                run_one(v_dvd[i], v_dvs[i], v_sgn[i][0], 1'b0, q);
                run_one(v_dvd[i], v_dvs[i], v_sgn[i][0], 1'b1, r);
                check_word("quotient", q, v_q[i]);
                check_word("remainder", r, v_r[i]);
                check_word("quotient*divisor+remainder", q * v_dvs[i] + r, v_dvd[i]);
            end
        end
    endtask

    task automatic random_traffic();
        apb_data_t st;
        word_t     res;
        word_t     a;
        word_t     b;
        logic      sgn;
        logic      rem;
        int        issued;
        int        n;
        issued = 0;
        n = 0;
        while ((issued < RAND_OPS || exp_q.size() > 0) && n < RAND_LOOP_LIMIT) begin
            reg_read(ADDR_STATUS, st, 1'b0);
            if (st[COUNT_W-1:0] != '0) begin
                reg_read(ADDR_RESULT, res, 1'b0);
                checks++;
                assert (exp_q.size() > 0) else begin
                    $display("result queue returned data that was never issued");
                    errors++;
                end
                if (exp_q.size() > 0)
                    check_word("result", res, exp_q.pop_front());
            end
            if (!st[STATUS_NO_CREDIT_BIT] && issued < RAND_OPS) begin
                a = $urandom;
                b = $urandom;
                case ($urandom % 8)
                    0: b = '0;
                    1: b = '1;
                    2: b = $urandom % 16;
                    3: a = 32'h8000_0000;
                    default: ;
                endcase
                sgn = $urandom % 2;
                rem = $urandom % 2;
                exp_q.push_back(ref_div(a, b, sgn, rem));
                issue(a, b, sgn, rem);
                issued++;
            end
            n++;
        end
        if (n >= RAND_LOOP_LIMIT)
            abort_run("random traffic did not drain within the loop limit");
    endtask

    initial begin
        int unsigned seed_val;
        apb_data_t   st;
        apb_data_t   d;
        word_t       a;
        word_t       b;
        clk = 1'b0;
        rstn = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        checks = 0;
        errors = 0;
        test_mark = 0;
        seed_val = $urandom(32'ha909ac93);
        load_vectors();
        repeat (8) @(posedge clk);
        #2 rstn = 1'b1;
        @(posedge clk);
        #2;

        file_tests(0);
        end_test(1, "unsigned division");
        file_tests(1);
        end_test(2, "signed division");
        file_tests(2);
        end_test(3, "division by zero");

        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            a = $urandom;
            b = ($urandom % 1000) + 1;
            exp_q.push_back(ref_div(a, b, i[0], i[1]));
            issue(a, b, i[0], i[1]);
        end
        wait_count(QUEUE_DEPTH, st);
        check_word("status.no_credit", word_t'(st[STATUS_NO_CREDIT_BIT]), 1);
        reg_write(ADDR_CMD, '0, 1'b1);      // refused, no credit
        reg_read(ADDR_STATUS, st, 1'b0);
        check_word("status.count", word_t'(st[COUNT_W-1:0]), QUEUE_DEPTH);
        check_word("status.no_credit", word_t'(st[STATUS_NO_CREDIT_BIT]), 1);  // no launch
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            reg_read(ADDR_RESULT, d, 1'b0);
            check_word("result", d, exp_q.pop_front());
        end
        end_test(4, "pipelining and order");

        reg_read(ADDR_RESULT, d, 1'b1);
        check_word("prdata", d, '0);
        reg_read(5'h14, d, 1'b1);
        reg_write(5'h1C, 32'h1, 1'b1);
        reg_write(ADDR_STATUS, 32'h1, 1'b1);
        reg_write(ADDR_DIVIDEND, 32'h1357_9BDF, 1'b0);
        reg_write(ADDR_DIVISOR, 32'h2468_ACE0, 1'b0);
        reg_read(ADDR_DIVIDEND, d, 1'b0);
        check_word("dividend", d, 32'h1357_9BDF);
        reg_read(ADDR_DIVISOR, d, 1'b0);
        check_word("divisor", d, 32'h2468_ACE0);
        end_test(5, "errors and register readback");

        random_traffic();
        end_test(6, "random traffic");

        $display("total: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- div_apb_top.sv
`timescale 1ns/1ps
`default_nettype none

module div_apb_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  apb_regs_pkg::apb_addr_t paddr,
    input  apb_regs_pkg::apb_data_t pwdata,
    output apb_regs_pkg::apb_data_t prdata,
    output logic                    pready,
    output logic                    pslverr
);
    import div_pkg::*;
    import apb_regs_pkg::*;

    logic   launch_valid;
    word_t  launch_dividend;
    word_t  launch_divisor;
    logic   launch_neg_q;
    logic   launch_neg_r;
    logic   launch_sel_rem;
    logic   out_valid;
    word_t  out_quotient;
    word_t  out_remainder;
    logic   out_neg_q;
    logic   out_neg_r;
    logic   out_sel_rem;
    logic   pop;
    logic   no_credit;
    count_t count;
    word_t  head_data;

    div_apb_slave u_slave (
        .clk             (clk),
        .rstn            (rstn),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .no_credit       (no_credit),
        .count           (count),
        .head_data       (head_data),
        .launch_valid    (launch_valid),
        .launch_dividend (launch_dividend),
        .launch_divisor  (launch_divisor),
        .launch_neg_q    (launch_neg_q),
        .launch_neg_r    (launch_neg_r),
        .launch_sel_rem  (launch_sel_rem),
        .pop             (pop)
    );

    div_pipe u_pipe (
        .clk             (clk),
        .rstn            (rstn),
        .launch_valid    (launch_valid),
        .launch_dividend (launch_dividend),
        .launch_divisor  (launch_divisor),
        .launch_neg_q    (launch_neg_q),
        .launch_neg_r    (launch_neg_r),
        .launch_sel_rem  (launch_sel_rem),
        .out_valid       (out_valid),
        .out_quotient    (out_quotient),
        .out_remainder   (out_remainder),
        .out_neg_q       (out_neg_q),
        .out_neg_r       (out_neg_r),
        .out_sel_rem     (out_sel_rem)
    );

    div_result_queue u_queue (
        .clk           (clk),
        .rstn          (rstn),
        .launch_valid  (launch_valid),
        .out_valid     (out_valid),
        .out_quotient  (out_quotient),
        .out_remainder (out_remainder),
        .out_neg_q     (out_neg_q),
        .out_neg_r     (out_neg_r),
        .out_sel_rem   (out_sel_rem),
        .pop           (pop),
        .head_data     (head_data),
        .count         (count),
        .no_credit     (no_credit)
    );

endmodule

`default_nettype wire

//--- div_result_queue.sv
`timescale 1ns/1ps
`default_nettype none

module div_result_queue (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 launch_valid,
    input  logic                 out_valid,
    input  div_pkg::word_t       out_quotient,
    input  div_pkg::word_t       out_remainder,
    input  logic                 out_neg_q,
    input  logic                 out_neg_r,
    input  logic                 out_sel_rem,
    input  logic                 pop,
    output div_pkg::word_t       head_data,
    output apb_regs_pkg::count_t count,
    output logic                 no_credit
);
    import div_pkg::*;
    import apb_regs_pkg::*;

    word_t                  quot_fix;
    word_t                  rem_fix;
    word_t                  res_word;
    word_t                  mem [QUEUE_DEPTH];
    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    count_t                 credits;

    // sign correction and selection
    assign quot_fix = out_neg_q ? -out_quotient : out_quotient;
    assign rem_fix = out_neg_r ? -out_remainder : out_remainder;
    assign res_word = out_sel_rem ? rem_fix : quot_fix;

    always_ff @(posedge clk) begin
        if (out_valid)
            mem[wr_ptr] <= res_word;
    end

    assign head_data = mem[rd_ptr];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (out_valid)
                wr_ptr <= wr_ptr + 1'b1;    // depth is a power of two
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            count <= '0;
        end else begin
            case ({out_valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // a credit covers one queue slot from launch until pop,
    // so a finished division always finds room
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            credits <= count_t'(QUEUE_DEPTH);
        end else begin
            case ({launch_valid, pop})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    assign no_credit = (credits == '0);

endmodule

`default_nettype wire

//--- div_apb_slave.sv
`timescale 1ns/1ps
`default_nettype none

module div_apb_slave (
    input  logic                      clk,
    input  logic                      rstn,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  apb_regs_pkg::apb_addr_t   paddr,
    input  apb_regs_pkg::apb_data_t   pwdata,
    output apb_regs_pkg::apb_data_t   prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      no_credit,
    input  apb_regs_pkg::count_t      count,
    input  div_pkg::word_t            head_data,
    output logic                      launch_valid,
    output div_pkg::word_t            launch_dividend,
    output div_pkg::word_t            launch_divisor,
    output logic                      launch_neg_q,
    output logic                      launch_neg_r,
    output logic                      launch_sel_rem,
    output logic                      pop
);
    import div_pkg::*;
    import apb_regs_pkg::*;

    word_t dividend_q;
    word_t divisor_q;
    logic  access;
    logic  wr_en;
    logic  rd_en;
    logic  addr_ok;
    logic  q_empty;
    logic  cmd_go;
    logic  dvd_neg;
    logic  dvs_neg;

    assign access = psel & penable;         // no wait states
    assign wr_en = access & pwrite;
    assign rd_en = access & ~pwrite;
    assign q_empty = (count == '0);
    assign pready = 1'b1;

    // legal address and direction
    always_comb begin
        case (paddr)
            ADDR_DIVIDEND, ADDR_DIVISOR: addr_ok = 1'b1;
            ADDR_CMD:                    addr_ok = pwrite;
            ADDR_STATUS, ADDR_RESULT:    addr_ok = ~pwrite;
            default:                     addr_ok = 1'b0;
        endcase
    end

    assign pslverr = access & (~addr_ok
                               | (wr_en & (paddr == ADDR_CMD) & no_credit)
                               | (rd_en & (paddr == ADDR_RESULT) & q_empty));

    assign cmd_go = wr_en & (paddr == ADDR_CMD) & ~no_credit;
    assign pop = rd_en & (paddr == ADDR_RESULT) & ~q_empty;

    assign dvd_neg = pwdata[CMD_SIGNED_BIT] & dividend_q[XLEN-1];
    assign dvs_neg = pwdata[CMD_SIGNED_BIT] & divisor_q[XLEN-1];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            dividend_q <= '0;
            divisor_q <= '0;
        end else begin
            if (wr_en && paddr == ADDR_DIVIDEND)
                dividend_q <= pwdata;
            if (wr_en && paddr == ADDR_DIVISOR)
                divisor_q <= pwdata;
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            launch_valid <= 1'b0;
        else
            launch_valid <= cmd_go;
    end

    // magnitudes and sign tags for the pipe
    always_ff @(posedge clk) begin
        if (cmd_go) begin
            launch_dividend <= dvd_neg ? -dividend_q : dividend_q;
            launch_divisor <= dvs_neg ? -divisor_q : divisor_q;
            launch_neg_q <= (dvd_neg ^ dvs_neg) & (divisor_q != '0);  // x/0 stays all ones
            launch_neg_r <= dvd_neg;
            launch_sel_rem <= pwdata[CMD_REM_BIT];
        end
    end

    always_comb begin
        prdata = '0;
        case (paddr)
            ADDR_DIVIDEND: prdata = dividend_q;
            ADDR_DIVISOR:  prdata = divisor_q;
            ADDR_STATUS: begin
                prdata[COUNT_W-1:0] = count;
                prdata[STATUS_NO_CREDIT_BIT] = no_credit;
            end
            ADDR_RESULT:   prdata = q_empty ? '0 : head_data;
            default:       prdata = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- div_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module div_pipe (
    input  logic           clk,
    input  logic           rstn,
    input  logic           launch_valid,
    input  div_pkg::word_t launch_dividend,
    input  div_pkg::word_t launch_divisor,
    input  logic           launch_neg_q,
    input  logic           launch_neg_r,
    input  logic           launch_sel_rem,
    output logic           out_valid,
    output div_pkg::word_t out_quotient,
    output div_pkg::word_t out_remainder,
    output logic           out_neg_q,
    output logic           out_neg_r,
    output logic           out_sel_rem
);
    import div_pkg::*;

    logic [STAGES-1:0] vld_s;
    word_t             rem_s [STAGES];
    word_t             quot_s [STAGES];
    word_t             dvd_s [STAGES];
    word_t             dvs_s [STAGES];
    tag_t              tag_s [STAGES];
    tag_t              launch_tags;

    always_comb begin
        launch_tags = '0;
        launch_tags[TAG_NEG_Q] = launch_neg_q;
        launch_tags[TAG_NEG_R] = launch_neg_r;
        launch_tags[TAG_SEL_REM] = launch_sel_rem;
    end

    for (genvar i = 0; i < STAGES; i++) begin : g_stage
        logic     en_in;
        partial_t part_in;
        word_t    dvs_in;
        word_t    quot_in;
        word_t    dvd_in;
        tag_t     tag_in;

        if (i == 0) begin : g_first
            assign en_in = launch_valid;
            assign part_in = {{XLEN{1'b0}}, launch_dividend[XLEN-1]};  // zero remainder, msb
            assign dvs_in = launch_divisor;
            assign quot_in = '0;
            assign dvd_in = launch_dividend;
            assign tag_in = launch_tags;
        end else begin : g_next
            assign en_in = vld_s[i-1];
            assign part_in = {rem_s[i-1], dvd_s[i-1][XLEN-1-i]};     // next dividend bit
            assign dvs_in = dvs_s[i-1];
            assign quot_in = quot_s[i-1];
            assign dvd_in = dvd_s[i-1];
            assign tag_in = tag_s[i-1];
        end

        div_cell u_cell (
            .clk         (clk),
            .rstn        (rstn),
            .en          (en_in),
            .partial     (part_in),
            .divisor     (dvs_in),
            .quotient_in (quot_in),
            .dividend_in (dvd_in),
            .tags_in     (tag_in),
            .valid       (vld_s[i]),
            .remainder   (rem_s[i]),
            .quotient    (quot_s[i]),
            .dividend_kp (dvd_s[i]),
            .divisor_kp  (dvs_s[i]),
            .tags_kp     (tag_s[i])
        );
    end

    assign out_valid = vld_s[STAGES-1];
    assign out_quotient = quot_s[STAGES-1];
    assign out_remainder = rem_s[STAGES-1];
    assign out_neg_q = tag_s[STAGES-1][TAG_NEG_Q];
    assign out_neg_r = tag_s[STAGES-1][TAG_NEG_R];
    assign out_sel_rem = tag_s[STAGES-1][TAG_SEL_REM];

endmodule

`default_nettype wire

//--- div_cell.sv
`timescale 1ns/1ps
`default_nettype none

module div_cell (
    input  logic              clk,
    input  logic              rstn,
    input  logic              en,
    input  div_pkg::partial_t partial,
    input  div_pkg::word_t    divisor,
    input  div_pkg::word_t    quotient_in,
    input  div_pkg::word_t    dividend_in,
    input  div_pkg::tag_t     tags_in,
    output logic              valid,
    output div_pkg::word_t    remainder,
    output div_pkg::word_t    quotient,
    output div_pkg::word_t    dividend_kp,
    output div_pkg::word_t    divisor_kp,
    output div_pkg::tag_t     tags_kp
);
    import div_pkg::*;

    partial_t diff;
    logic     ge;

    assign diff = partial - {1'b0, divisor};
    assign ge = (partial >= {1'b0, divisor});  // restore when smaller

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn)
            valid <= 1'b0;
        else
            valid <= en;
    end

    // result fits XLEN bits since partial < 2 * divisor
    always_ff @(posedge clk) begin
        if (en) begin
            remainder <= ge ? diff[XLEN-1:0] : partial[XLEN-1:0];
            quotient <= {quotient_in[XLEN-2:0], ge};
            dividend_kp <= dividend_in;
            divisor_kp <= divisor;
            tags_kp <= tags_in;
        end
    end

endmodule

`default_nettype wire

//--- apb_regs_pkg.sv
`default_nettype none

package apb_regs_pkg;

    localparam int APB_AW = 5;
    localparam int APB_DW = 32;

    typedef logic [APB_AW-1:0] apb_addr_t;  // byte address
    typedef logic [APB_DW-1:0] apb_data_t;

    // register map
    localparam apb_addr_t ADDR_DIVIDEND = 5'h00;   // rw
    localparam apb_addr_t ADDR_DIVISOR = 5'h04;    // rw
    localparam apb_addr_t ADDR_CMD = 5'h08;        // wo, launches
    localparam apb_addr_t ADDR_STATUS = 5'h0C;     // ro
    localparam apb_addr_t ADDR_RESULT = 5'h10;     // ro, pops

    // result queue
    localparam int QUEUE_DEPTH = 8;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    localparam int COUNT_W = 4;             // holds 0..QUEUE_DEPTH

    typedef logic [COUNT_W-1:0] count_t;

    // status fields, count sits in the low bits
    localparam int STATUS_NO_CREDIT_BIT = 8;

endpackage

`default_nettype wire

//--- div_pkg.sv
`default_nettype none

package div_pkg;

    localparam int XLEN = 32;               // operand width
    localparam int STAGES = XLEN;           // one cell per quotient bit

    // operands, quotient, remainder and result words
    typedef logic [XLEN-1:0] word_t;

    // partial remainder with the next dividend bit appended
    typedef logic [XLEN:0] partial_t;

    // command word bits
    localparam int CMD_SIGNED_BIT = 0;
    localparam int CMD_REM_BIT = 1;

    // tags carried alongside each division
    localparam int TAG_W = 3;
    localparam int TAG_NEG_Q = 0;           // negate quotient
    localparam int TAG_NEG_R = 1;           // negate remainder
    localparam int TAG_SEL_REM = 2;         // keep remainder, else quotient

    typedef logic [TAG_W-1:0] tag_t;

endpackage

`default_nettype wire
